/* rtl/cic_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and types shared by the I/Q CIC decimator
// Rates from 1 to MAX_RATE only, gain shift of 0 to 7
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cic_pkg;

  localparam int SAMPLE_WIDTH = 16;
  localparam int NUM_STAGES   = 4;
  localparam int MAX_RATE     = 256;
  localparam int RATE_WIDTH   = $clog2(MAX_RATE + 1);
  // Worst case growth is NUM_STAGES * log2(MAX_RATE)
  localparam int ACC_WIDTH    = SAMPLE_WIDTH + NUM_STAGES * RATE_WIDTH;
  localparam int GAIN_WIDTH   = 3;
  // Room for the largest fine gain shift before saturation
  localparam int SHIFT_WIDTH  = SAMPLE_WIDTH + 2**GAIN_WIDTH - 1;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic signed [ACC_WIDTH-1:0]    acc_t;

  typedef struct packed {
    sample_t i;
    sample_t q;
  } iq_t;

  typedef struct packed {
    iq_t  data;
    logic last;
  } iq_beat_t;

  typedef struct packed {
    logic [RATE_WIDTH-1:0] rate;
    logic [GAIN_WIDTH-1:0] gain;
  } cfg_t;

endpackage

/* rtl/cic_rate_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rate 0 or above MAX_RATE is refused with cfg_error
// cfg_stb and in_stb must not arrive in one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cic_rate_ctrl (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            cfg_stb,
  input  cic_pkg::cfg_t                   cfg,
  input  logic                            in_stb,
  input  cic_pkg::iq_beat_t               in_beat,
  output logic                            rate_stb,
  output logic [cic_pkg::RATE_WIDTH-1:0]  rate,
  output logic [cic_pkg::GAIN_WIDTH-1:0]  gain,
  output logic                            cfg_error,
  output logic                            smp_stb,
  output cic_pkg::iq_beat_t               smp_beat
);

  logic init_pend;
  logic rate_ok;

  assign rate_ok = (cfg.rate != '0) && (cfg.rate <= cic_pkg::MAX_RATE);

  always_ff @(posedge clk) begin
    if (reset) begin
      init_pend <= 1'b1;
      rate_stb  <= 1'b0;
      rate      <= cic_pkg::MAX_RATE[cic_pkg::RATE_WIDTH-1:0];
      gain      <= '0;
      cfg_error <= 1'b0;
      smp_stb   <= 1'b0;
      smp_beat  <= '0;
    end else begin
      // First cycle out of reset loads the filter counters
      init_pend <= 1'b0;
      rate_stb  <= init_pend | (cfg_stb & rate_ok);
      cfg_error <= cfg_stb & ~rate_ok;
      if (cfg_stb && rate_ok) begin
        rate <= cfg.rate;
        gain <= cfg.gain;
      end
      smp_stb <= in_stb;
      if (in_stb) begin
        smp_beat <= in_beat;
      end
    end
  end

  // Filters index their shift table by this value
  rate_in_range: assert property (
    @(posedge clk) disable iff (reset)
    (rate != '0) && (rate <= cic_pkg::MAX_RATE)
  );

endmodule

/* rtl/cic_decimate.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One real channel with a latency of 2*N+2 per output
// Gain is normalised only exactly for power-of-two rates
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cic_decimate (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            rate_stb,
  input  logic [cic_pkg::RATE_WIDTH-1:0]  rate,
  input  logic                            strobe_in,
  input  logic                            last_in,
  input  cic_pkg::sample_t                signal_in,
  output logic                            strobe_out,
  output logic                            last_out,
  output cic_pkg::sample_t                signal_out
);

  cic_pkg::acc_t                    integ [cic_pkg::NUM_STAGES];
  logic [cic_pkg::NUM_STAGES-1:0]   strobe_integ;
  logic [cic_pkg::NUM_STAGES-1:0]   last_integ;
  logic                             last_hold;

  logic [cic_pkg::RATE_WIDTH-1:0]   counter;
  cic_pkg::acc_t                    sampler;
  logic                             strobe_sampler;
  logic                             last_sampler;

  cic_pkg::acc_t                    comb_dly [cic_pkg::NUM_STAGES];
  cic_pkg::acc_t                    comb     [cic_pkg::NUM_STAGES];
  logic [cic_pkg::NUM_STAGES-1:0]   strobe_comb;
  logic [cic_pkg::NUM_STAGES-1:0]   last_comb;

  cic_pkg::sample_t                 shifted [cic_pkg::MAX_RATE+1];

  // ceil(N*log2(r)) in integer math as clog2 of r**N
  function automatic int norm_shift(longint unsigned r);
    longint unsigned growth;
    growth = 1;
    for (int s = 0; s < cic_pkg::NUM_STAGES; s++) begin
      growth = growth * r;
    end
    return $clog2(growth);
  endfunction

  // Integrators
  always_ff @(posedge clk) begin
    if (reset) begin
      strobe_integ <= '0;
      last_integ   <= '0;
      for (int s = 0; s < cic_pkg::NUM_STAGES; s++) begin
        integ[s] <= '0;
      end
    end else begin
      strobe_integ <= {strobe_integ[cic_pkg::NUM_STAGES-2:0], strobe_in};
      if (strobe_in) begin
        last_integ[0] <= last_in;
        integ[0]      <= integ[0] + cic_pkg::acc_t'(signal_in);
      end
      for (int s = 1; s < cic_pkg::NUM_STAGES; s++) begin
        if (strobe_integ[s-1]) begin
          last_integ[s] <= last_integ[s-1];
          integ[s]      <= integ[s] + integ[s-1];
        end
      end
    end
  end

  // Rate sampler giving one output per rate strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      counter        <= '0;
      sampler        <= '0;
      strobe_sampler <= 1'b0;
      last_sampler   <= 1'b0;
      last_hold      <= 1'b0;
    end else begin
      strobe_sampler <= 1'b0;
      if (rate_stb) begin
        counter <= rate;
      end else if (strobe_integ[cic_pkg::NUM_STAGES-1]) begin
        if (counter <= 1) begin
          counter        <= rate;
          sampler        <= integ[cic_pkg::NUM_STAGES-1];
          strobe_sampler <= 1'b1;
          last_sampler   <= last_integ[cic_pkg::NUM_STAGES-1] | last_hold;
          last_hold      <= 1'b0;
        end else begin
          counter   <= counter - 1'b1;
          // Keep a last seen mid-group until the group is sampled
          last_hold <= last_hold | last_integ[cic_pkg::NUM_STAGES-1];
        end
      end
    end
  end

  // Combs
  always_ff @(posedge clk) begin
    if (reset) begin
      strobe_comb <= '0;
      last_comb   <= '0;
      for (int s = 0; s < cic_pkg::NUM_STAGES; s++) begin
        comb_dly[s] <= '0;
        comb[s]     <= '0;
      end
    end else begin
      strobe_comb <= {strobe_comb[cic_pkg::NUM_STAGES-2:0], strobe_sampler};
      if (strobe_sampler) begin
        last_comb[0] <= last_sampler;
        comb_dly[0]  <= sampler;
        comb[0]      <= sampler - comb_dly[0];
      end
      for (int s = 1; s < cic_pkg::NUM_STAGES; s++) begin
        if (strobe_comb[s-1]) begin
          last_comb[s] <= last_comb[s-1];
          comb_dly[s]  <= comb[s-1];
          comb[s]      <= comb[s-1] - comb_dly[s];
        end
      end
    end
  end

  // Gain normalising shift for every legal rate
  assign shifted[0] = comb[cic_pkg::NUM_STAGES-1][cic_pkg::SAMPLE_WIDTH-1:0];
  for (genvar r = 1; r <= cic_pkg::MAX_RATE; r++) begin : g_shift
    assign shifted[r] =
      comb[cic_pkg::NUM_STAGES-1][norm_shift(r) +: cic_pkg::SAMPLE_WIDTH];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      strobe_out <= 1'b0;
      last_out   <= 1'b0;
      signal_out <= '0;
    end else begin
      strobe_out <= strobe_comb[cic_pkg::NUM_STAGES-1];
      if (strobe_comb[cic_pkg::NUM_STAGES-1]) begin
        last_out   <= last_comb[cic_pkg::NUM_STAGES-1];
        signal_out <= shifted[rate];
      end
    end
  end

  // A rate reload would swallow a sample in the counter
  no_stb_on_reload: assert property (
    @(posedge clk) disable iff (reset)
    !(strobe_in && rate_stb)
  );

  // A reload as a strobe leaves the last integrator drops it from the count
  no_reload_at_sampler: assert property (
    @(posedge clk) disable iff (reset)
    !(strobe_integ[cic_pkg::NUM_STAGES-1] && rate_stb)
  );

endmodule

/* rtl/cic_iq_out.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I and Q strobes must coincide, Q last is not used
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cic_iq_out (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [cic_pkg::GAIN_WIDTH-1:0]  gain,
  input  logic                            i_stb,
  input  logic                            i_last,
  input  cic_pkg::sample_t                i_data,
  input  logic                            q_stb,
  input  cic_pkg::sample_t                q_data,
  output logic                            out_stb,
  output cic_pkg::iq_beat_t               out_beat
);

  // Left shift with clamp to the signed sample range
  function automatic cic_pkg::sample_t sat_shift(cic_pkg::sample_t x,
                                                 logic [cic_pkg::GAIN_WIDTH-1:0] g);
    logic signed [cic_pkg::SHIFT_WIDTH-1:0]                      wide;
    logic [cic_pkg::SHIFT_WIDTH-cic_pkg::SAMPLE_WIDTH:0]         top;
    wide = {{(cic_pkg::SHIFT_WIDTH-cic_pkg::SAMPLE_WIDTH){x[cic_pkg::SAMPLE_WIDTH-1]}}, x};
    wide = wide <<< g;
    // Bits above the sample sign must all match it
    top = wide[cic_pkg::SHIFT_WIDTH-1:cic_pkg::SAMPLE_WIDTH-1];
    if ((top != '0) && (top != '1)) begin
      if (wide[cic_pkg::SHIFT_WIDTH-1]) begin
        return {1'b1, {(cic_pkg::SAMPLE_WIDTH-1){1'b0}}};
      end else begin
        return {1'b0, {(cic_pkg::SAMPLE_WIDTH-1){1'b1}}};
      end
    end
    return wide[cic_pkg::SAMPLE_WIDTH-1:0];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      out_stb  <= 1'b0;
      out_beat <= '0;
    end else begin
      out_stb <= i_stb;
      if (i_stb) begin
        out_beat.data.i <= sat_shift(i_data, gain);
        out_beat.data.q <= sat_shift(q_data, gain);
        out_beat.last   <= i_last;
      end
    end
  end

  // Both filters run from one strobe and one rate
  iq_stb_aligned: assert property (
    @(posedge clk) disable iff (reset)
    i_stb == q_stb
  );

endmodule

/* rtl/cic_ddc_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// No back-pressure, every out_stb must be taken
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cic_ddc_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               cfg_stb,
  input  cic_pkg::cfg_t      cfg,
  input  logic               in_stb,
  input  cic_pkg::iq_beat_t  in_beat,
  output logic               out_stb,
  output cic_pkg::iq_beat_t  out_beat,
  output logic               cfg_error
);

  logic                            rate_stb;
  logic [cic_pkg::RATE_WIDTH-1:0]  rate;
  logic [cic_pkg::GAIN_WIDTH-1:0]  gain;
  logic                            smp_stb;
  cic_pkg::iq_beat_t               smp_beat;

  logic                            i_stb;
  logic                            i_last;
  cic_pkg::sample_t                i_data;
  logic                            q_stb;
  cic_pkg::sample_t                q_data;

  cic_rate_ctrl cic_rate_ctrl_i (
    .clk       (clk),
    .reset     (reset),
    .cfg_stb   (cfg_stb),
    .cfg       (cfg),
    .in_stb    (in_stb),
    .in_beat   (in_beat),
    .rate_stb  (rate_stb),
    .rate      (rate),
    .gain      (gain),
    .cfg_error (cfg_error),
    .smp_stb   (smp_stb),
    .smp_beat  (smp_beat)
  );

  cic_decimate cic_i (
    .clk        (clk),
    .reset      (reset),
    .rate_stb   (rate_stb),
    .rate       (rate),
    .strobe_in  (smp_stb),
    .last_in    (smp_beat.last),
    .signal_in  (smp_beat.data.i),
    .strobe_out (i_stb),
    .last_out   (i_last),
    .signal_out (i_data)
  );

  // Q last matches I last, so it is dropped here
  cic_decimate cic_q (
    .clk        (clk),
    .reset      (reset),
    .rate_stb   (rate_stb),
    .rate       (rate),
    .strobe_in  (smp_stb),
    .last_in    (smp_beat.last),
    .signal_in  (smp_beat.data.q),
    .strobe_out (q_stb),
    .last_out   (),
    .signal_out (q_data)
  );

  cic_iq_out cic_iq_out_i (
    .clk      (clk),
    .reset    (reset),
    .gain     (gain),
    .i_stb    (i_stb),
    .i_last   (i_last),
    .i_data   (i_data),
    .q_stb    (q_stb),
    .q_data   (q_data),
    .out_stb  (out_stb),
    .out_beat (out_beat)
  );

endmodule

/* verif/cic_ddc_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Feeds whole groups only and drains between runs
// Data is compared from output NUM_STAGES of each run
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cic_ddc_tb;

  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_LIMIT  = 32;
  localparam int IDLE_CYCLES  = 16;
  localparam int RUN_OVERHEAD = 64;
  localparam int NUM_RUNS     = 14;
  // Strobes of all runs, groups times rate
  localparam int STROBE_BUDGET = 8 * (1 + 2 + 5 + 64) + 3 * 10 * 16 + 2 * 10 * 4
                                 + 2 * 10 * 8 + 8 * 4 + 2 * 8 * 2;
  localparam int TIMEOUT_CYCLES = 2 * RESET_CYCLES + STROBE_BUDGET
                                  + NUM_RUNS * RUN_OVERHEAD + 100;

  logic               clk;
  logic               reset;
  logic               cfg_stb;
  cic_pkg::cfg_t      cfg;
  logic               in_stb;
  cic_pkg::iq_beat_t  in_beat;
  logic               out_stb;
  cic_pkg::iq_beat_t  out_beat;
  logic               cfg_error;

  int                 errors;
  int                 tests;
  int                 out_total;
  int                 err_total;
  int                 run_base;
  int                 out_idx;
  int                 exp_count;
  int                 last_grp;
  logic               chk_data;
  logic               quiet_chk;
  cic_pkg::sample_t   exp_i;
  cic_pkg::sample_t   exp_q;
  logic [31:0]        lcg_state;

  cic_ddc_top cic_ddc_top_i (
    .clk       (clk),
    .reset     (reset),
    .cfg_stb   (cfg_stb),
    .cfg       (cfg),
    .in_stb    (in_stb),
    .in_beat   (in_beat),
    .out_stb   (out_stb),
    .out_beat  (out_beat),
    .cfg_error (cfg_error)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  // x times 2**g, clamped to the signed sample range
  function automatic cic_pkg::sample_t expected_gain(cic_pkg::sample_t x, int g);
    longint scaled;
    longint max_v;
    max_v  = (longint'(1) << (cic_pkg::SAMPLE_WIDTH - 1)) - 1;
    scaled = longint'(x) * (longint'(1) << g);
    if (scaled > max_v) begin
      scaled = max_v;
    end else if (scaled < -max_v - 1) begin
      scaled = -max_v - 1;
    end
    return cic_pkg::sample_t'(scaled);
  endfunction

  assign out_idx = out_total - run_base;

  always @(posedge clk) begin
    if (reset) begin
      out_total <= 0;
      err_total <= 0;
    end else begin
      if (out_stb) begin
        out_total <= out_total + 1;
      end
      if (cfg_error) begin
        err_total <= err_total + 1;
      end
    end
  end

  quiet_in_reset: assert property (
    @(posedge clk) quiet_chk |-> !out_stb && !cfg_error && out_beat == '0
  ) else begin
    errors++;
    $display("Fail %0t: output not idle around reset", $time);
  end

  settled_data: assert property (
    @(posedge clk) disable iff (reset)
    out_stb && chk_data && out_idx >= cic_pkg::NUM_STAGES |->
      out_beat.data.i == exp_i && out_beat.data.q == exp_q
  ) else begin
    errors++;
    $display("Fail %0t: output %0d is I %0d Q %0d, expected I %0d Q %0d", $time,
             $sampled(out_idx), $sampled(out_beat.data.i), $sampled(out_beat.data.q),
             exp_i, exp_q);
  end

  last_flag: assert property (
    @(posedge clk) disable iff (reset)
    out_stb |-> out_beat.last == (out_idx == last_grp)
  ) else begin
    errors++;
    $display("Fail %0t: last flag wrong on output %0d", $time, $sampled(out_idx));
  end

  no_extra_output: assert property (
    @(posedge clk) disable iff (reset)
    out_stb |-> out_idx < exp_count
  ) else begin
    errors++;
    $display("Fail %0t: more than %0d outputs in a run", $time, exp_count);
  end

  // One cycle after a write with rate 0 or above MAX_RATE, and only then
  cfg_error_pulse: assert property (
    @(posedge clk) disable iff (reset)
    cfg_error == $past(cfg_stb && (cfg.rate == '0 || int'(cfg.rate) > cic_pkg::MAX_RATE))
  ) else begin
    errors++;
    $display("Fail %0t: cfg_error does not match the rate written", $time);
  end

  task automatic load_cfg(int rate, int gain);
    @(negedge clk);
    cfg_stb  = 1'b1;
    cfg.rate = rate[cic_pkg::RATE_WIDTH-1:0];
    cfg.gain = gain[cic_pkg::GAIN_WIDTH-1:0];
    @(negedge clk);
    cfg_stb = 1'b0;
    @(negedge clk);
  endtask

  // Feeds groups*rate strobes of constant I and Q, then waits for the outputs
  task automatic run_block(int rate, int gain, int groups, cic_pkg::sample_t x_i,
                           cic_pkg::sample_t x_q, int last_at, logic check);
    int waited;
    @(negedge clk);
    run_base  = out_total;
    exp_count = groups;
    exp_i     = expected_gain(x_i, gain);
    exp_q     = expected_gain(x_q, gain);
    chk_data  = check;
    last_grp  = (last_at < 0) ? -1 : last_at / rate;
    for (int n = 0; n < rate * groups; n++) begin
      in_stb         = 1'b1;
      in_beat.data.i = x_i;
      in_beat.data.q = x_q;
      in_beat.last   = (n == last_at);
      @(negedge clk);
    end
    in_stb       = 1'b0;
    in_beat.last = 1'b0;
    waited       = 0;
    while (out_idx < groups && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    // Room for a stray output past the fixed latency
    repeat (IDLE_CYCLES) @(negedge clk);
    count_ok: assert (out_idx == groups) else begin
      errors++;
      $display("Fail %0t: %0d outputs for %0d groups at rate %0d", $time, out_idx,
               groups, rate);
    end
    chk_data = 1'b0;
  endtask

  task automatic report_test(string name, int err_before);
    tests++;
    $display("test %-10s done, %0d errors", name, errors - err_before);
  endtask

  initial begin
    int                err_mark;
    int                cfg_errs;
    int                rates [4];
    cic_pkg::sample_t  x;
    rates     = '{1, 2, 5, 64};
    errors    = 0;
    tests     = 0;
    lcg_state = 32'd39;
    run_base  = 0;
    exp_count = 0;
    last_grp  = -1;
    chk_data  = 1'b0;
    quiet_chk = 1'b0;
    exp_i     = '0;
    exp_q     = '0;
    reset     = 1'b1;
    cfg_stb   = 1'b0;
    cfg       = '0;
    in_stb    = 1'b0;
    in_beat   = '0;

    err_mark = errors;
    @(negedge clk);
    quiet_chk = 1'b1;
    repeat (RESET_CYCLES - 1) @(negedge clk);
    reset = 1'b0;
    repeat (8) @(negedge clk);
    quiet_chk = 1'b0;
    report_test("reset", err_mark);

    err_mark = errors;
    foreach (rates[k]) begin
      x = $signed(next_random());
      load_cfg(rates[k], 0);
      run_block(rates[k], 0, 8, x, x, -1, (rates[k] & (rates[k] - 1)) == 0);
    end
    report_test("count", err_mark);

    err_mark = errors;
    load_cfg(16, 0);
    repeat (3) begin
      x = $signed(next_random());
      run_block(16, 0, 10, x, x, -1, 1'b1);
    end
    load_cfg(4, 2);
    x = $signed(next_random());
    run_block(4, 2, 10, x, x, -1, 1'b1);
    // Large shift, mostly saturates
    load_cfg(4, 7);
    x = $signed(next_random());
    run_block(4, 7, 10, x, x, -1, 1'b1);
    report_test("dc_gain", err_mark);

    err_mark = errors;
    load_cfg(8, 0);
    repeat (2) begin
      x = $signed(next_random()) >>> 1;
      run_block(8, 0, 10, x, -x, -1, 1'b1);
    end
    report_test("iq", err_mark);

    err_mark = errors;
    load_cfg(4, 0);
    x = $signed(next_random());
    run_block(4, 0, 8, x, x, int'(next_random() % 16'd32), 1'b1);
    report_test("last", err_mark);

    err_mark = errors;
    load_cfg(2, 0);
    run_block(2, 0, 8, x, x, -1, 1'b1);
    cfg_errs = err_total;
    load_cfg(0, 3);
    load_cfg(cic_pkg::MAX_RATE + 1, 5);
    error_count_ok: assert (err_total == cfg_errs + 2) else begin
      errors++;
      $display("Fail %0t: %0d cfg_error pulses for 2 bad rates", $time,
               err_total - cfg_errs);
    end
    run_block(2, 0, 8, x, x, -1, 1'b1);
    report_test("reject", err_mark);

    $display("tests run %0d, failed checks %0d", tests, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* cic_ddc.f */
rtl/cic_pkg.sv
rtl/cic_rate_ctrl.sv
rtl/cic_decimate.sv
rtl/cic_iq_out.sv
rtl/cic_ddc_top.sv
verif/cic_ddc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cic_ddc_tb
LINT_TOP  ?= cic_ddc_top
FILELIST  ?= cic_ddc.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing
JOBS      ?= 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^RESULT: PASS$$"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
